// ==== all.f ====
+incdir+design
+incdir+verification
design/track_adapter_pkg.sv
design/track_dispatcher.sv
design/track_convert_lane.sv
design/track_collector.sv
design/external_track_adapter.sv
verification/track_adapter_tb.sv

// ==== design/external_track_adapter.sv ====
/*
 * External track adapter top level. Dispatcher feeds NUM_LANES conversion
 * lanes round-robin, the collector merges their results in order.
 */

`timescale 1ns/1ps

`include "track_adapter_defs.svh"

module external_track_adapter
    import track_adapter_pkg::*;
#(
    parameter int NUM_LANES = `NUM_LANES
) (
    input  logic        clk,
    input  logic        rst_n,
    input  frame_t      frame_in,
    input  src_id_t     src_in,
    input  logic        frame_valid,
    output logic        frame_ready,
    input  coord_t      origin_lat,         // Deg x 1e7
    input  coord_t      origin_lon,
    input  coord_t      origin_alt,         // Metres
    output logic        track_valid,
    output track_id_t   track_id,
    output src_map_t    track_source,
    output coord_t      pos_east,
    output coord_t      pos_north,
    output coord_t      pos_up,
    output coord_t      vel_east,
    output coord_t      vel_north,
    output coord_t      vel_up,
    output cov_t        cov_pos,
    output cov_t        cov_vel,
    output track_time_t timestamp,
    output count_t      tracks_received,
    output count_t      tracks_converted
);

    // Dispatcher to lanes
    logic [NUM_LANES-1:0] lane_start;
    logic [NUM_LANES-1:0] lane_busy;
    frame_t               lane_frame;
    src_id_t              lane_src;

    // ----------------------------------------
    // Lane results
    logic [NUM_LANES-1:0] res_valid;
    track_id_t            res_id        [NUM_LANES];
    src_map_t             res_src_map   [NUM_LANES];
    coord_t               res_east      [NUM_LANES];
    coord_t               res_north     [NUM_LANES];
    coord_t               res_up        [NUM_LANES];
    coord_t               res_vel_east  [NUM_LANES];
    coord_t               res_vel_north [NUM_LANES];
    coord_t               res_vel_up    [NUM_LANES];
    cov_t                 res_cov_pos   [NUM_LANES];
    cov_t                 res_cov_vel   [NUM_LANES];
    track_time_t          res_time      [NUM_LANES];

    track_dispatcher #(.NUM_LANES(NUM_LANES)) i_track_dispatcher (
        .clk             (clk),
        .rst_n           (rst_n),
        .frame_in        (frame_in),
        .src_in          (src_in),
        .frame_valid     (frame_valid),
        .frame_ready     (frame_ready),
        .lane_busy       (lane_busy),
        .lane_start      (lane_start),
        .lane_frame      (lane_frame),
        .lane_src        (lane_src),
        .tracks_received (tracks_received)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        track_convert_lane i_track_convert_lane (
            .clk           (clk),
            .rst_n         (rst_n),
            .start         (lane_start[g]),
            .frame         (lane_frame),
            .src           (lane_src),
            .origin_lat    (origin_lat),
            .origin_lon    (origin_lon),
            .origin_alt    (origin_alt),
            .busy          (lane_busy[g]),
            .res_valid     (res_valid[g]),
            .res_id        (res_id[g]),
            .res_src_map   (res_src_map[g]),
            .res_east      (res_east[g]),
            .res_north     (res_north[g]),
            .res_up        (res_up[g]),
            .res_vel_east  (res_vel_east[g]),
            .res_vel_north (res_vel_north[g]),
            .res_vel_up    (res_vel_up[g]),
            .res_cov_pos   (res_cov_pos[g]),
            .res_cov_vel   (res_cov_vel[g]),
            .res_time      (res_time[g])
        );
    end

    track_collector #(.NUM_LANES(NUM_LANES)) i_track_collector (
        .clk              (clk),
        .rst_n            (rst_n),
        .res_valid        (res_valid),
        .res_id           (res_id),
        .res_src_map      (res_src_map),
        .res_east         (res_east),
        .res_north        (res_north),
        .res_up           (res_up),
        .res_vel_east     (res_vel_east),
        .res_vel_north    (res_vel_north),
        .res_vel_up       (res_vel_up),
        .res_cov_pos      (res_cov_pos),
        .res_cov_vel      (res_cov_vel),
        .res_time         (res_time),
        .track_valid      (track_valid),
        .track_id         (track_id),
        .track_source     (track_source),
        .pos_east         (pos_east),
        .pos_north        (pos_north),
        .pos_up           (pos_up),
        .vel_east         (vel_east),
        .vel_north        (vel_north),
        .vel_up           (vel_up),
        .cov_pos          (cov_pos),
        .cov_vel          (cov_vel),
        .timestamp        (timestamp),
        .tracks_converted (tracks_converted)
    );

endmodule

// ==== design/track_adapter_defs.svh ====
/*
 * Widths, lane count, source codes and conversion constants for the
 * external track adapter. Included by the package and by every RTL file
 * that needs a constant.
 */

`ifndef TRACK_ADAPTER_DEFS_SVH
`define TRACK_ADAPTER_DEFS_SVH

// ----------------------------------------
// Widths
`define COORD_WIDTH     32      // Coordinates, velocities, time
`define WIDE_WIDTH      64      // Lat/lon and ENU intermediates
`define TRACK_ID_WIDTH  10
`define FRAME_WIDTH     256
`define SRC_WIDTH       4
`define SRC_MAP_WIDTH   8       // Wide enough for the ADS-B bit

`define NUM_LANES       2       // Default lane count

// ----------------------------------------
// Source codes, anything else is generic
`define SRC_LINK16      4'd1
`define SRC_ASTERIX     4'd2
`define SRC_ADSB        4'd5

// Flat-earth conversion
`define METERS_PER_DEG  111320
`define DEG_SCALE       10000000    // Degrees in 1e-7 units

`endif

// ==== design/track_adapter_pkg.sv ====
/*
 * Vector types shared by the track adapter RTL and its testbench.
 * Import with a wildcard in the module header.
 */

`include "track_adapter_defs.svh"

package track_adapter_pkg;

    // Raw input frame and its source tag
    typedef logic [`FRAME_WIDTH-1:0]    frame_t;
    typedef logic [`SRC_WIDTH-1:0]      src_id_t;

    // One-hot source bitmap
    typedef logic [`SRC_MAP_WIDTH-1:0]  src_map_t;

    typedef logic [`TRACK_ID_WIDTH-1:0] track_id_t;

    // Metres or metres per second
    typedef logic signed [`COORD_WIDTH-1:0] coord_t;

    // Lat, lon and ENU before truncation
    typedef logic signed [`WIDE_WIDTH-1:0]  wide_t;

    typedef logic [`COORD_WIDTH-1:0]    cov_t;          // Variance, unsigned
    typedef logic [`COORD_WIDTH-1:0]    track_time_t;   // Source time, unsigned
    typedef logic [31:0]                count_t;        // Status counters

endpackage

// ==== design/track_collector.sv ====
/*
 * Output side of the track adapter. Registers the result of whichever lane
 * strobes and counts converted tracks. Fields hold between strobes.
 */

`timescale 1ns/1ps

`include "track_adapter_defs.svh"

module track_collector
    import track_adapter_pkg::*;
#(
    parameter int NUM_LANES = `NUM_LANES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LANES-1:0] res_valid,
    input  track_id_t            res_id        [NUM_LANES],
    input  src_map_t             res_src_map   [NUM_LANES],
    input  coord_t               res_east      [NUM_LANES],
    input  coord_t               res_north     [NUM_LANES],
    input  coord_t               res_up        [NUM_LANES],
    input  coord_t               res_vel_east  [NUM_LANES],
    input  coord_t               res_vel_north [NUM_LANES],
    input  coord_t               res_vel_up    [NUM_LANES],
    input  cov_t                 res_cov_pos   [NUM_LANES],
    input  cov_t                 res_cov_vel   [NUM_LANES],
    input  track_time_t          res_time      [NUM_LANES],
    output logic                 track_valid,
    output track_id_t            track_id,
    output src_map_t             track_source,
    output coord_t               pos_east,
    output coord_t               pos_north,
    output coord_t               pos_up,
    output coord_t               vel_east,
    output coord_t               vel_north,
    output coord_t               vel_up,
    output cov_t                 cov_pos,
    output cov_t                 cov_vel,
    output track_time_t          timestamp,
    output count_t               tracks_converted
);

    localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [SEL_W-1:0] sel;      // Strobing lane

    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (res_valid[i]) sel = SEL_W'(i);
        end
    end

    // ----------------------------------------
    // Strobe and counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            track_valid      <= 1'b0;
            tracks_converted <= '0;
        end else begin
            track_valid <= |res_valid;
            if (|res_valid) tracks_converted <= tracks_converted + 1'b1;
        end
    end

    // Payload from the selected lane
    always_ff @(posedge clk) begin
        if (|res_valid) begin
            track_id     <= res_id[sel];
            track_source <= res_src_map[sel];
            pos_east     <= res_east[sel];
            pos_north    <= res_north[sel];
            pos_up       <= res_up[sel];
            vel_east     <= res_vel_east[sel];
            vel_north    <= res_vel_north[sel];
            vel_up       <= res_vel_up[sel];
            cov_pos      <= res_cov_pos[sel];
            cov_vel      <= res_cov_vel[sel];
            timestamp    <= res_time[sel];
        end
    end

    // Equal lane latency keeps finishes one per cycle
    a_one_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(res_valid)
    );

endmodule

// ==== design/track_convert_lane.sv ====
/*
 * One conversion lane. Captures a frame on start, parses it per source
 * format, then converts lat/lon/alt to local metres against the origin.
 * res_valid strobes two cycles after the capture edge.
 */

`timescale 1ns/1ps

`include "track_adapter_defs.svh"

module track_convert_lane
    import track_adapter_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  frame_t      frame,
    input  src_id_t     src,
    input  coord_t      origin_lat,
    input  coord_t      origin_lon,
    input  coord_t      origin_alt,
    output logic        busy,
    output logic        res_valid,
    output track_id_t   res_id,
    output src_map_t    res_src_map,
    output coord_t      res_east,
    output coord_t      res_north,
    output coord_t      res_up,
    output coord_t      res_vel_east,
    output coord_t      res_vel_north,
    output coord_t      res_vel_up,
    output cov_t        res_cov_pos,
    output cov_t        res_cov_vel,
    output track_time_t res_time
);

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_PARSE,
        LANE_CONVERT
    } lane_state_t;

    lane_state_t state;

    frame_t  frame_q;           // Held frame
    src_id_t src_q;

    // Parser outputs, combinational
    wide_t       lat_c, lon_c;
    coord_t      alt_c, ve_c, vn_c, vu_c;
    cov_t        cpos_c, cvel_c;
    track_time_t time_c;

    // Parse stage registers
    track_id_t   p_id;
    src_map_t    p_map;
    wide_t       p_lat, p_lon;
    coord_t      p_alt, p_ve, p_vn, p_vu;
    cov_t        p_cpos, p_cvel;
    track_time_t p_time;

    assign busy = (state != LANE_IDLE);

    // ----------------------------------------
    // Lane FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LANE_IDLE;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                LANE_IDLE: begin
                    if (start) state <= LANE_PARSE;
                end
                LANE_PARSE: state <= LANE_CONVERT;
                LANE_CONVERT: begin
                    state     <= LANE_IDLE;
                    res_valid <= 1'b1;      // Results land this edge
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Format parsing
    always_comb begin
        vn_c   = '0;                        // Only generic carries north vel
        cpos_c = 32'd10000;
        cvel_c = 32'd100;
        case (src_q)
            `SRC_LINK16: begin
                lat_c  = wide_t'($signed(frame_q[47:16])) * 21457;    // To 1e-7 deg
                lon_c  = wide_t'($signed(frame_q[79:48])) * 21457;
                alt_c  = coord_t'($signed(frame_q[111:80]) * 3);
                ve_c   = coord_t'(wide_t'($signed(frame_q[143:128])) * 257 / 1000);
                vu_c   = coord_t'(wide_t'($signed(frame_q[159:144])) * 6 / 1000);
                time_c = track_time_t'(frame_q[191:176]);            // Zero-extended
            end
            `SRC_ASTERIX: begin
                lat_c  = wide_t'($signed(frame_q[55:24]));
                lon_c  = wide_t'($signed(frame_q[87:56]));
                alt_c  = coord_t'(wide_t'($signed(frame_q[103:88])) * 8);
                ve_c   = coord_t'(wide_t'($signed(frame_q[119:104])) / 4);
                vu_c   = coord_t'(wide_t'($signed(frame_q[135:120])) * 6 / 1000);
                time_c = frame_q[167:136];
                cpos_c = 32'd2500;
                cvel_c = 32'd25;
            end
            `SRC_ADSB: begin
                lat_c  = wide_t'($signed(frame_q[55:24]));
                lon_c  = wide_t'($signed(frame_q[87:56]));
                alt_c  = coord_t'(wide_t'($signed(frame_q[103:88])) * 30 / 100);   // ft to m
                ve_c   = coord_t'(wide_t'($signed(frame_q[119:104])) * 514 / 1000);
                vu_c   = coord_t'(wide_t'($signed(frame_q[135:120])) * 6 / 1000);
                time_c = frame_q[167:136];
                cpos_c = 32'd400;
                cvel_c = 32'd4;
            end
            default: begin                  // Generic pass-through
                lat_c  = $signed(frame_q[79:16]);
                lon_c  = $signed(frame_q[143:80]);
                alt_c  = $signed(frame_q[175:144]);
                ve_c   = $signed(frame_q[207:176]);
                vn_c   = $signed(frame_q[239:208]);
                vu_c   = '0;
                time_c = frame_q[255:224];
            end
        endcase
    end

    // ----------------------------------------
    // Capture, parse and convert registers
    always_ff @(posedge clk) begin
        if (start && state == LANE_IDLE) begin
            frame_q <= frame;
            src_q   <= src;
        end
        if (state == LANE_PARSE) begin
            p_id   <= frame_q[`TRACK_ID_WIDTH-1:0];     // Low bits of id
            p_map  <= src_q[3] ? '0 : src_map_t'(8'd1 << src_q[2:0]);
            p_lat  <= lat_c;
            p_lon  <= lon_c;
            p_alt  <= alt_c;
            p_ve   <= ve_c;
            p_vn   <= vn_c;
            p_vu   <= vu_c;
            p_cpos <= cpos_c;
            p_cvel <= cvel_c;
            p_time <= time_c;
        end
        if (state == LANE_CONVERT) begin
            // Linear lat/lon to metres, 64-bit then cut
            res_north     <= coord_t'((p_lat - origin_lat) * `METERS_PER_DEG / `DEG_SCALE);
            res_east      <= coord_t'((p_lon - origin_lon) * `METERS_PER_DEG / `DEG_SCALE);
            res_up        <= p_alt - origin_alt;
            res_id        <= p_id;
            res_src_map   <= p_map;
            res_vel_east  <= p_ve;
            res_vel_north <= p_vn;
            res_vel_up    <= p_vu;
            res_cov_pos   <= p_cpos;
            res_cov_vel   <= p_cvel;
            res_time      <= p_time;
        end
    end

    // Dispatcher must wait for this lane to drain
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> !busy
    );

endmodule

// ==== design/track_dispatcher.sv ====
/*
 * Input side of the track adapter. Takes frames on a valid/ready handshake
 * and starts the lane at the round-robin pointer. Ready follows that lane.
 */

`timescale 1ns/1ps

`include "track_adapter_defs.svh"

module track_dispatcher
    import track_adapter_pkg::*;
#(
    parameter int NUM_LANES = `NUM_LANES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  frame_t               frame_in,
    input  src_id_t              src_in,
    input  logic                 frame_valid,
    output logic                 frame_ready,
    input  logic [NUM_LANES-1:0] lane_busy,
    output logic [NUM_LANES-1:0] lane_start,
    output frame_t               lane_frame,
    output src_id_t              lane_src,
    output count_t               tracks_received
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] ptr;      // Next lane to feed
    logic             accept;

    assign frame_ready = !lane_busy[ptr];
    assign accept      = frame_valid && frame_ready;

    // Frame goes to every lane but only the pointed one starts
    assign lane_frame = frame_in;
    assign lane_src   = src_in;
    assign lane_start = accept ? (NUM_LANES'(1) << ptr) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr             <= '0;
            tracks_received <= '0;
        end else if (accept) begin
            tracks_received <= tracks_received + 1'b1;
            if (ptr == PTR_W'(NUM_LANES - 1)) begin
                ptr <= '0;      // Wrap
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // A started lane must read busy on the next edge so no later start lands on it
    a_start_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (lane_start != '0) |=> ((lane_busy & $past(lane_start)) == $past(lane_start))
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the track adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module track_adapter_tb -o sim_track_adapter
./obj_dir/sim_track_adapter > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation passed"

// ==== verification/track_adapter_tests.svh ====
/*
 * Directed tests for the external track adapter. Included into the
 * testbench module. Each task drives frames and checks the response.
 */

    // ----------------------------------------
    // Idle state right after reset
    task automatic idle_after_reset();
        @(negedge clk);
        check_eq("frame_ready", 32'(frame_ready), 32'd1);
        check_eq("track_valid", 32'(track_valid), 32'd0);
        check_eq("tracks_received", tracks_received, 32'd0);
        check_eq("tracks_converted", tracks_converted, 32'd0);
    endtask

    // One frame in flight at a time
    task automatic send_single(input frame_t f, input src_id_t s);
        int acc;
        send_frame(f, s, acc);
        release_input();
        wait_drained();
    endtask

    task automatic single_formats();
        frame_t f;
        f          = '0;                    // Link 16 air track
        f[15:0]    = 16'h0123;
        f[47:16]   = 32'sd1000;
        f[79:48]   = -32'sd2000;
        f[111:80]  = 32'sd500;
        f[143:128] = -16'sd400;
        f[159:144] = 16'sd1000;
        f[191:176] = 16'hbeef;
        send_single(f, `SRC_LINK16);
        f          = '0;                    // ASTERIX CAT048
        f[15:0]    = 16'h0456;
        f[55:24]   = 32'sd473000000;
        f[87:56]   = 32'sd85000000;
        f[103:88]  = 16'sd1200;
        f[119:104] = -16'sd350;
        f[135:120] = 16'sd250;
        f[167:136] = 32'h0001_2345;
        send_single(f, `SRC_ASTERIX);
        f          = '0;                    // ADS-B with an id wider than 10 bits
        f[15:0]    = 16'hfabc;
        f[55:24]   = -32'sd338000000;
        f[87:56]   = -32'sd1200000000;
        f[103:88]  = 16'sd30000;
        f[119:104] = 16'sd450;
        f[135:120] = -16'sd640;
        f[167:136] = 32'hdead_0042;
        send_single(f, `SRC_ADSB);
    endtask

    // ----------------------------------------
    // Generic layout with 64-bit lat/lon
    function automatic frame_t generic_frame(input logic [15:0] id, input longint lat,
                                             input longint lon, input int alt, input int ve,
                                             input int vn, input int tm);
        frame_t f;
        f          = '0;
        f[15:0]    = id;
        f[79:16]   = lat;
        f[143:80]  = lon;
        f[175:144] = alt;
        f[207:176] = ve;
        f[239:208] = vn;
        f[255:224] = tm;
        return f;
    endfunction

    task automatic send_generic(input frame_t f, input src_id_t s);
        send_single(f, s);
        check_eq("cov_pos", cov_pos, 32'd10000);    // Generic default
        check_eq("cov_vel", cov_vel, 32'd100);
    endtask

    task automatic generic_origin();
        @(negedge clk);
        origin_lat = 32'sd473000000;
        origin_lon = 32'sd85000000;
        origin_alt = 32'sd400;
        send_generic(generic_frame(16'h0010, 64'sd472900000, 64'sd85100000,
                                   350, 12, -7, 32'h0000_0100), 4'd0);
        send_generic(generic_frame(16'h0311, 64'sd473250000, 64'sd84700000,
                                   1000, -25, 40, 32'h0000_0200), 4'd3);
        send_generic(generic_frame(16'h03ff, 64'sd470000000, 64'sd90000000,
                                   -20, 0, 3, 32'h7fff_ffff), 4'd7);
    endtask

    // ----------------------------------------
    // Back-to-back random frames with valid held high
    task automatic burst_backpressure();
        int      acc [12];
        frame_t  f;
        src_id_t s;
        for (int k = 0; k < 12; k++) begin
            f = rand_bits(256);
            s = src_id_t'(rand_bits(4));
            send_frame(f, s, acc[k]);
        end
        release_input();
        // Two lanes busy three cycles each so ready drops every third cycle
        for (int k = 1; k < 12; k++) begin
            check_eq("accept spacing", 32'(acc[k] - acc[k-1]), (k % 2 == 1) ? 32'd1 : 32'd2);
        end
        wait_drained();
    endtask

    task automatic final_counts();
        @(negedge clk);
        check_eq("tracks_received", tracks_received, 32'(frames_sent));
        check_eq("tracks_converted", tracks_converted, 32'(frames_sent));
    endtask

// ==== verification/track_adapter_tb.sv ====
/*
 * Directed testbench for the external track adapter. Drives frames on the
 * falling clock edge, models the parse and convert rules in software and
 * checks every track that leaves the DUT, in acceptance order.
 */

`timescale 1ns/1ps

`include "track_adapter_defs.svh"

module track_adapter_tb
    import track_adapter_pkg::*;
();

    localparam int          CLK_PERIOD      = 100;
    localparam int          RESET_CYCLES    = 16;
    localparam int          NUM_TESTS       = 5;
    localparam int          NUM_FRAMES      = 18;      // 3 + 3 + 12
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * NUM_FRAMES * 10 + 100;
    localparam int          DRAIN_LIMIT     = 10;      // Cycles to wait for outstanding tracks
    localparam logic [31:0] LFSR_SEED       = 32'h6c63;

    logic        clk = 1'b0;
    logic        rst_n;
    frame_t      frame_in;
    src_id_t     src_in;
    logic        frame_valid;
    logic        frame_ready;
    coord_t      origin_lat, origin_lon, origin_alt;
    logic        track_valid;
    track_id_t   track_id;
    src_map_t    track_source;
    coord_t      pos_east, pos_north, pos_up;
    coord_t      vel_east, vel_north, vel_up;
    cov_t        cov_pos, cov_vel;
    track_time_t timestamp;
    count_t      tracks_received, tracks_converted;

    // Scoreboard with the oldest accepted frame at the front
    frame_t      exp_frame_q [$];
    src_id_t     exp_src_q   [$];
    int          exp_cycle_q [$];       // Accept edge of each frame

    logic [31:0] lfsr        = LFSR_SEED;
    int          cycle_cnt   = 0;       // Rising edges so far
    int          frames_sent = 0;

    // Model outputs for the track under check
    logic [31:0] exp_id, exp_map, exp_time;
    logic [31:0] exp_east, exp_north, exp_up;
    logic [31:0] exp_vel_east, exp_vel_north, exp_vel_up;
    logic [31:0] exp_cov_pos, exp_cov_vel;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    external_track_adapter i_external_track_adapter (
        .clk              (clk),
        .rst_n            (rst_n),
        .frame_in         (frame_in),
        .src_in           (src_in),
        .frame_valid      (frame_valid),
        .frame_ready      (frame_ready),
        .origin_lat       (origin_lat),
        .origin_lon       (origin_lon),
        .origin_alt       (origin_alt),
        .track_valid      (track_valid),
        .track_id         (track_id),
        .track_source     (track_source),
        .pos_east         (pos_east),
        .pos_north        (pos_north),
        .pos_up           (pos_up),
        .vel_east         (vel_east),
        .vel_north        (vel_north),
        .vel_up           (vel_up),
        .cov_pos          (cov_pos),
        .cov_vel          (cov_vel),
        .timestamp        (timestamp),
        .tracks_received  (tracks_received),
        .tracks_converted (tracks_converted)
    );

    // ----------------------------------------
    // Error handling and checks
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH at %0t: %s = 0x%08h, expected 0x%08h",
                                     $time, name, actual, expected));
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [255:0] rand_bits(input int n);
        logic [255:0] v;
        logic         b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 32'h8020_0003;     // Taps 32, 22, 2, 1
            v[i] = b;
        end
        return v;
    endfunction

    // Signed fields of a frame
    function automatic int s32(input frame_t f, input int lsb);
        return f[lsb +: 32];
    endfunction

    function automatic shortint s16(input frame_t f, input int lsb);
        return f[lsb +: 16];
    endfunction

    // ----------------------------------------
    // Reference model of the format table and flat-earth ENU
    function automatic void model_track(input frame_t f, input src_id_t s);
        longint lat;
        longint lon;
        longint alt;
        longint ve;
        longint vu;
        exp_vel_north = 32'd0;
        exp_cov_pos   = 32'd10000;
        exp_cov_vel   = 32'd100;
        vu            = 0;
        if (s == `SRC_LINK16) begin
            lat      = longint'(s32(f, 16)) * 21457;
            lon      = longint'(s32(f, 48)) * 21457;
            alt      = longint'(s32(f, 80)) * 3;
            ve       = longint'(s16(f, 128)) * 257 / 1000;
            vu       = longint'(s16(f, 144)) * 6 / 1000;
            exp_time = {16'd0, f[191:176]};         // Unsigned 16-bit time
        end else if (s == `SRC_ASTERIX || s == `SRC_ADSB) begin
            lat      = longint'(s32(f, 24));
            lon      = longint'(s32(f, 56));
            vu       = longint'(s16(f, 120)) * 6 / 1000;
            exp_time = f[167:136];
            if (s == `SRC_ASTERIX) begin
                alt         = longint'(s16(f, 88)) * 8;
                ve          = longint'(s16(f, 104)) / 4;
                exp_cov_pos = 32'd2500;
                exp_cov_vel = 32'd25;
            end else begin
                alt         = longint'(s16(f, 88)) * 30 / 100;    // Feet
                ve          = longint'(s16(f, 104)) * 514 / 1000; // Knots
                exp_cov_pos = 32'd400;
                exp_cov_vel = 32'd4;
            end
        end else begin
            lat           = f[79:16];
            lon           = f[143:80];
            alt           = longint'(s32(f, 144));
            ve            = longint'(s32(f, 176));
            exp_vel_north = f[239:208];
            exp_time      = f[255:224];
        end
        exp_id       = {22'd0, f[9:0]};
        exp_map      = (s < 4'd8) ? (32'd1 << s) : 32'd0;
        exp_north    = 32'((lat - longint'(origin_lat)) * `METERS_PER_DEG / `DEG_SCALE);
        exp_east     = 32'((lon - longint'(origin_lon)) * `METERS_PER_DEG / `DEG_SCALE);
        exp_up       = 32'(alt - longint'(origin_alt));
        exp_vel_east = 32'(ve);
        exp_vel_up   = 32'(vu);
    endfunction

    // ----------------------------------------
    // Drivers
    task automatic send_frame(input frame_t f, input src_id_t s, output int acc);
        @(negedge clk);
        frame_in    = f;
        src_in      = s;
        frame_valid = 1'b1;
        while (!frame_ready) @(negedge clk);    // Held until a lane frees up
        acc = cycle_cnt + 1;                    // Taken at the coming rising edge
        exp_frame_q.push_back(f);
        exp_src_q.push_back(s);
        exp_cycle_q.push_back(acc);
        frames_sent++;
    endtask

    task automatic release_input();
        @(negedge clk);
        frame_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_src_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_src_q.size() != 0) begin
            report_failure($sformatf("ERROR at %0t: no track_valid for %0d accepted frame(s)",
                                     $time, exp_src_q.size()));
        end
    endtask

    // Output monitor checks each strobe against the oldest frame
    task automatic check_track();
        frame_t  f;
        src_id_t s;
        int      acc;
        if (exp_src_q.size() == 0) begin
            report_failure($sformatf("ERROR at %0t: track_valid with no frame outstanding",
                                     $time));
        end else begin
            f   = exp_frame_q.pop_front();
            s   = exp_src_q.pop_front();
            acc = exp_cycle_q.pop_front();
            check_eq("track_valid latency", 32'(cycle_cnt - acc), 32'd3);
            model_track(f, s);
            check_eq("track_id", 32'(track_id), exp_id);
            check_eq("track_source", 32'(track_source), exp_map);
            check_eq("pos_east", pos_east, exp_east);
            check_eq("pos_north", pos_north, exp_north);
            check_eq("pos_up", pos_up, exp_up);
            check_eq("vel_east", vel_east, exp_vel_east);
            check_eq("vel_north", vel_north, exp_vel_north);
            check_eq("vel_up", vel_up, exp_vel_up);
            check_eq("cov_pos", cov_pos, exp_cov_pos);
            check_eq("cov_vel", cov_vel, exp_cov_vel);
            check_eq("timestamp", timestamp, exp_time);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && track_valid) check_track();
    end

    `include "track_adapter_tests.svh"

    // Watchdog sized from the test and frame counts
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("ERROR: watchdog expired after %0d cycles, a test is stuck",
                                 WATCHDOG_CYCLES));
    end

    initial begin
        rst_n       = 1'b0;
        frame_in    = '0;
        src_in      = '0;
        frame_valid = 1'b0;
        origin_lat  = '0;
        origin_lon  = '0;
        origin_alt  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        single_formats();
        generic_origin();
        burst_backpressure();
        final_counts();
        $display("TEST PASS");
        $finish;
    end

endmodule
